// ==== logic/exe_pkg.sv ====
/*
	shared types for the execute stage: ALU and jump encodings,
	the decoded control bundle and the two pipeline register payloads
*/
package exe_pkg;

	localparam int XLEN = 32;

	// ALU operation, chosen by the decoder
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_t;

	// next pc mode, zero means sequential
	typedef enum logic [3:0] {
		JMP_NONE  = 4'd0,
		JMP_JAL   = 4'd1,
		JMP_JALR  = 4'd2,
		JMP_BEQ   = 4'd3,
		JMP_BNE   = 4'd4,
		JMP_BLT   = 4'd5,
		JMP_BGE   = 4'd6,
		JMP_BLTU  = 4'd7,
		JMP_BGEU  = 4'd8,
		JMP_MRET  = 4'd9,
		JMP_ECALL = 4'd10
	} jump_t;

	typedef struct packed {
		alu_op_t     aluop;
		logic        src_a;       // 0 rs1, 1 pc
		logic        src_b;       // 0 rs2, 1 imm
		jump_t       jump;
		logic        gpr_we;
		logic [3:0]  gpr_waddr;
		logic [2:0]  gpr_wsel;
		logic        csr_we;
		logic [11:0] csr_waddr;
		logic [1:0]  csr_wsel;
		logic [7:0]  mem_wmask;
		logic [2:0]  mem_rmask;
		logic [1:0]  mem_rw;
		logic        fence_i;
		logic        is_break;
	} exe_ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		logic [XLEN-1:0] csr_rdata;
		exe_ctrl_t       ctrl;
	} id_exe_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		logic [XLEN-1:0] csr_rdata;
		logic [XLEN-1:0] alu_result;
		exe_ctrl_t       ctrl;
	} exe_mem_t;

endpackage

// ==== logic/exe_alu.sv ====
/*
	32-bit ALU for the execute unit, purely combinational
*/
`timescale 1ns/1ps

module exe_alu (
	input  logic [exe_pkg::XLEN-1:0] a,
	input  logic [exe_pkg::XLEN-1:0] b,
	input  exe_pkg::alu_op_t         aluop,
	output logic [exe_pkg::XLEN-1:0] result,
	output logic                     zf
);

	logic [4:0] shamt;

	// rv32 shifts only look at the low five bits
	assign shamt = b[4:0];

	always_comb begin
		case (aluop)
			exe_pkg::ALU_ADD: begin
				result = a + b;
			end
			exe_pkg::ALU_SUB: begin
				result = a - b;
			end
			exe_pkg::ALU_SLL: begin
				result = a << shamt;
			end
			exe_pkg::ALU_SLT: begin
				result = {{(exe_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			end
			exe_pkg::ALU_SLTU: begin
				result = {{(exe_pkg::XLEN-1){1'b0}}, a < b};
			end
			exe_pkg::ALU_XOR: begin
				result = a ^ b;
			end
			exe_pkg::ALU_SRL: begin
				result = a >> shamt;
			end
			exe_pkg::ALU_SRA: begin
				result = $signed(a) >>> shamt;
			end
			exe_pkg::ALU_OR: begin
				result = a | b;
			end
			exe_pkg::ALU_AND: begin
				result = a & b;
			end
			// lui style, operand b straight through
			exe_pkg::ALU_PASS_B: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zf = (result == '0);

endmodule

// ==== logic/exe_npc.sv ====
/*
	next pc and branch decision, fed by the ALU compare result
*/
`timescale 1ns/1ps

module exe_npc (
	input  logic [exe_pkg::XLEN-1:0] pc,
	input  logic [exe_pkg::XLEN-1:0] imm,
	input  logic [exe_pkg::XLEN-1:0] rs1_data,
	input  logic [exe_pkg::XLEN-1:0] mtvec,
	input  logic [exe_pkg::XLEN-1:0] mepc,
	input  exe_pkg::jump_t           jump,
	input  logic [exe_pkg::XLEN-1:0] alu_result,
	input  logic                     zf,
	output logic [exe_pkg::XLEN-1:0] npc
);

	logic [exe_pkg::XLEN-1:0] pc_plus4;
	logic [exe_pkg::XLEN-1:0] pc_target;
	logic [exe_pkg::XLEN-1:0] jalr_sum;
	logic                     taken;

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + imm;
	assign jalr_sum  = rs1_data + imm;

	// beq/bne rely on sub, the rest on slt/sltu bit 0
	always_comb begin
		case (jump)
			exe_pkg::JMP_BEQ:  taken = zf;
			exe_pkg::JMP_BNE:  taken = !zf;
			exe_pkg::JMP_BLT:  taken = alu_result[0];
			exe_pkg::JMP_BGE:  taken = !alu_result[0];
			exe_pkg::JMP_BLTU: taken = alu_result[0];
			exe_pkg::JMP_BGEU: taken = !alu_result[0];
			default:           taken = 1'b0;
		endcase
	end

	always_comb begin
		case (jump)
			exe_pkg::JMP_JAL:   npc = pc_target;
			exe_pkg::JMP_JALR:  npc = {jalr_sum[exe_pkg::XLEN-1:1], 1'b0};
			exe_pkg::JMP_MRET:  npc = mepc;
			exe_pkg::JMP_ECALL: npc = mtvec;
			exe_pkg::JMP_BEQ, exe_pkg::JMP_BNE, exe_pkg::JMP_BLT,
			exe_pkg::JMP_BGE, exe_pkg::JMP_BLTU, exe_pkg::JMP_BGEU: begin
				npc = taken ? pc_target : pc_plus4;
			end
			default:            npc = pc_plus4;
		endcase
	end

endmodule

// ==== logic/exe_unit.sv ====
/*
	execute unit with operand select, ALU, next pc and fence.i stall
	sits between the ID/EX and EX/MEM registers, combinational in between
*/
`timescale 1ns/1ps

module exe_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     id_valid,
	output logic                     id_ready,
	input  exe_pkg::id_exe_t         id_data,
	output logic                     ex_valid,
	input  logic                     ex_ready,
	output exe_pkg::exe_mem_t        ex_data,
	input  logic [exe_pkg::XLEN-1:0] mtvec,
	input  logic [exe_pkg::XLEN-1:0] mepc,
	input  logic                     flush_done,
	output logic                     flush_req,
	output logic                     fence_retire,
	output logic                     redirect_valid,
	output logic [exe_pkg::XLEN-1:0] redirect_pc
);

	logic [exe_pkg::XLEN-1:0] alu_a;
	logic [exe_pkg::XLEN-1:0] alu_b;
	logic [exe_pkg::XLEN-1:0] alu_result;
	logic                     alu_zf;
	logic                     stall;
	logic                     xfer;

	// fence.i waits here until the icache flush is through
	assign stall     = id_data.ctrl.fence_i && !flush_done;
	assign flush_req = id_valid && stall;

	// back-pressure upstream, hold valid downstream
	assign ex_valid = id_valid && !stall;
	assign id_ready = ex_ready && !stall;
	assign xfer     = ex_valid && ex_ready;

	assign alu_a = id_data.ctrl.src_a ? id_data.pc : id_data.rs1_data;
	assign alu_b = id_data.ctrl.src_b ? id_data.imm : id_data.rs2_data;

	exe_alu alu_i (
		.a      (alu_a),
		.b      (alu_b),
		.aluop  (id_data.ctrl.aluop),
		.result (alu_result),
		.zf     (alu_zf)
	);

	exe_npc npc_i (
		.pc         (id_data.pc),
		.imm        (id_data.imm),
		.rs1_data   (id_data.rs1_data),
		.mtvec      (mtvec),
		.mepc       (mepc),
		.jump       (id_data.ctrl.jump),
		.alu_result (alu_result),
		.zf         (alu_zf),
		.npc        (redirect_pc)
	);

	// one pulse per instruction, on its move into EX/MEM
	assign redirect_valid = xfer && (id_data.ctrl.jump != exe_pkg::JMP_NONE);
	assign fence_retire   = xfer && id_data.ctrl.fence_i;

	always_comb begin
		ex_data.pc         = id_data.pc;
		ex_data.imm        = id_data.imm;
		ex_data.rs1_data   = id_data.rs1_data;
		ex_data.rs2_data   = id_data.rs2_data;
		ex_data.csr_rdata  = id_data.csr_rdata;
		ex_data.alu_result = alu_result;
		ex_data.ctrl       = id_data.ctrl;
	end

	// a stalled fence.i stays in ID/EX until the flush is through
	a_stall_holds_instr: assert property (@(posedge clk) disable iff (rst)
		flush_req |=> id_valid && $stable(id_data));

	// done is only reported while a fence.i waits here
	a_done_with_fence: assert property (@(posedge clk) disable iff (rst)
		flush_done |-> id_valid && id_data.ctrl.fence_i);

endmodule

// ==== logic/stage_reg.sv ====
/*
	one-entry valid/ready pipeline register, payload type set by the parent
*/
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// empty, or the current entry leaves this cycle
	assign in_ready = !valid_q || out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

	// a request that is held off stays put until taken
	a_in_held_when_stalled: assert property (@(posedge clk) disable iff (rst)
		in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

// ==== logic/icache_flush_ctrl.sv ====
/*
	icache flush sequencer for fence.i that counts the flush time
	and then holds done until the fence.i leaves the execute unit
*/
`timescale 1ns/1ps

module icache_flush_ctrl #(
	parameter int FLUSH_CYCLES = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic flush_req,
	input  logic fence_retire,
	output logic flush_done,
	output logic icache_flush
);

	localparam int CNT_W = (FLUSH_CYCLES > 1) ? $clog2(FLUSH_CYCLES) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FLUSH,
		ST_DONE
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (flush_req) state <= ST_FLUSH;
				end
				ST_FLUSH: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(FLUSH_CYCLES - 1)) state <= ST_DONE;
				end
				// wait for the fence.i to move on
				ST_DONE: begin
					if (fence_retire) state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign icache_flush = (state == ST_FLUSH);
	assign flush_done   = (state == ST_DONE);

	// the fence.i keeps asking for the whole flush
	a_req_held_while_flushing: assert property (@(posedge clk) disable iff (rst)
		icache_flush |-> flush_req);

endmodule

// ==== logic/exe_top.sv ====
/*
	execute stage top: ID/EX register, execute unit, icache flush
	controller and EX/MEM register, valid/ready on both ends
*/
`timescale 1ns/1ps

module exe_top #(
	parameter int FLUSH_CYCLES = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  exe_pkg::id_exe_t         in_data,
	output logic                     out_valid,
	input  logic                     out_ready,
	output exe_pkg::exe_mem_t        out_data,
	input  logic [exe_pkg::XLEN-1:0] mtvec,
	input  logic [exe_pkg::XLEN-1:0] mepc,
	output logic                     redirect_valid,
	output logic [exe_pkg::XLEN-1:0] redirect_pc,
	output logic                     icache_flush
);

	logic              id_valid;
	logic              id_ready;
	exe_pkg::id_exe_t  id_data;
	logic              ex_valid;
	logic              ex_ready;
	exe_pkg::exe_mem_t ex_data;
	logic              flush_req;
	logic              flush_done;
	logic              fence_retire;

	stage_reg #(.payload_t(exe_pkg::id_exe_t)) id_exe_reg (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (id_valid),
		.out_ready (id_ready),
		.out_data  (id_data)
	);

	exe_unit exe_unit_i (
		.clk            (clk),
		.rst            (rst),
		.id_valid       (id_valid),
		.id_ready       (id_ready),
		.id_data        (id_data),
		.ex_valid       (ex_valid),
		.ex_ready       (ex_ready),
		.ex_data        (ex_data),
		.mtvec          (mtvec),
		.mepc           (mepc),
		.flush_done     (flush_done),
		.flush_req      (flush_req),
		.fence_retire   (fence_retire),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	icache_flush_ctrl #(.FLUSH_CYCLES(FLUSH_CYCLES)) flush_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.flush_req    (flush_req),
		.fence_retire (fence_retire),
		.flush_done   (flush_done),
		.icache_flush (icache_flush)
	);

	stage_reg #(.payload_t(exe_pkg::exe_mem_t)) exe_mem_reg (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (ex_valid),
		.in_ready  (ex_ready),
		.in_data   (ex_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

// ==== dv/exe_model.svh ====
/*
	reference model of the execute stage, included into the testbench module
	gives the expected ALU value, next pc and EX/MEM payload of an instruction
*/
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

function automatic logic [31:0] model_alu(input logic [31:0] a, input logic [31:0] b,
		input exe_pkg::alu_op_t op);
	logic [4:0] sh;
	logic       lt_s;
	sh = b[4:0];
	// signed compare from the sign bits, unsigned compare on a tie
	lt_s = (a[31] != b[31]) ? a[31] : (a < b);
	case (op)
		exe_pkg::ALU_ADD:    return a + b;
		exe_pkg::ALU_SUB:    return a - b;
		exe_pkg::ALU_SLL:    return a << sh;
		exe_pkg::ALU_SLT:    return {31'd0, lt_s};
		exe_pkg::ALU_SLTU:   return {31'd0, (a < b)};
		exe_pkg::ALU_XOR:    return a ^ b;
		exe_pkg::ALU_SRL:    return a >> sh;
		// logical shift, then fill the vacated top bits with the sign
		exe_pkg::ALU_SRA:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
		exe_pkg::ALU_OR:     return a | b;
		exe_pkg::ALU_AND:    return a & b;
		exe_pkg::ALU_PASS_B: return b;
		default:             return 32'd0;
	endcase
endfunction

// branch outcome straight from the register operands
function automatic logic model_taken(input exe_pkg::jump_t j, input logic [31:0] x,
		input logic [31:0] y);
	logic lt_s;
	lt_s = (x[31] != y[31]) ? x[31] : (x < y);
	case (j)
		exe_pkg::JMP_BEQ:  return x == y;
		exe_pkg::JMP_BNE:  return x != y;
		exe_pkg::JMP_BLT:  return lt_s;
		exe_pkg::JMP_BGE:  return !lt_s;
		exe_pkg::JMP_BLTU: return x < y;
		exe_pkg::JMP_BGEU: return !(x < y);
		default:           return 1'b0;
	endcase
endfunction

function automatic logic [31:0] model_npc(input exe_pkg::id_exe_t d, input logic [31:0] tvec,
		input logic [31:0] epc);
	case (d.ctrl.jump)
		exe_pkg::JMP_JAL:   return d.pc + d.imm;
		exe_pkg::JMP_JALR:  return (d.rs1_data + d.imm) & 32'hffff_fffe;
		exe_pkg::JMP_MRET:  return epc;
		exe_pkg::JMP_ECALL: return tvec;
		default: return model_taken(d.ctrl.jump, d.rs1_data, d.rs2_data) ?
			d.pc + d.imm : d.pc + 32'd4;
	endcase
endfunction

function automatic exe_pkg::exe_mem_t model_exe(input exe_pkg::id_exe_t d);
	exe_pkg::exe_mem_t e;
	logic [31:0]       a;
	logic [31:0]       b;
	a = d.ctrl.src_a ? d.pc : d.rs1_data;
	b = d.ctrl.src_b ? d.imm : d.rs2_data;
	e.pc         = d.pc;
	e.imm        = d.imm;
	e.rs1_data   = d.rs1_data;
	e.rs2_data   = d.rs2_data;
	e.csr_rdata  = d.csr_rdata;
	e.alu_result = model_alu(a, b, d.ctrl.aluop);
	e.ctrl       = d.ctrl;
	return e;
endfunction

`endif

// ==== dv/exe_tb.sv ====
/*
	testbench for exe_top with random instructions under random back-pressure,
	checked against exe_model.svh through scoreboard queues and built from tb.f
*/
`timescale 1ns/1ps

module exe_tb;

	localparam int FLUSH_CYCLES = 4;
	localparam int NUM_INSTR    = 600;
	localparam int CLK_PERIOD   = 20;

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic              in_ready;
	exe_pkg::id_exe_t  in_data;
	logic              out_valid;
	logic              out_ready;
	exe_pkg::exe_mem_t out_data;
	logic [31:0]       mtvec;
	logic [31:0]       mepc;
	logic              redirect_valid;
	logic [31:0]       redirect_pc;
	logic              icache_flush;

	exe_pkg::exe_mem_t exp_q[$];
	logic [31:0]       npc_q[$];
	logic              in_taken = 1'b0;
	int received = 0;
	int redirects = 0;
	int flush_run = 0;
	int flush_runs = 0;
	int fence_outs = 0;
	int err_result = 0;
	int err_redirect = 0;
	int err_flush = 0;
	int err_other = 0;

	`include "exe_model.svh"

	exe_top #(.FLUSH_CYCLES(FLUSH_CYCLES)) exe_top_i (
		.clk            (clk),
		.rst            (rst),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_data        (in_data),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_data       (out_data),
		.mtvec          (mtvec),
		.mepc           (mepc),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.icache_flush   (icache_flush)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_result(input string name, input exe_pkg::exe_mem_t exp,
			input exe_pkg::exe_mem_t act);
		if (act !== exp) begin
			err_result++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_redirect(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			err_redirect++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flush_len(input string name, input int exp, input int act);
		if (act != exp) begin
			err_flush++;
			$display("FAILED %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_other++;
			$display("FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	function automatic exe_pkg::id_exe_t random_instr();
		exe_pkg::id_exe_t d;
		d.pc              = $urandom() & 32'hffff_fffc;
		d.imm             = $urandom();
		d.rs1_data        = $urandom();
		// equal operands half the time so beq and bge get taken
		d.rs2_data        = ($urandom_range(1) == 0) ? d.rs1_data : $urandom();
		d.csr_rdata       = $urandom();
		d.ctrl.aluop      = exe_pkg::alu_op_t'(4'($urandom_range(10)));
		d.ctrl.src_a      = 1'($urandom_range(1));
		d.ctrl.src_b      = 1'($urandom_range(1));
		d.ctrl.gpr_we     = 1'($urandom_range(1));
		d.ctrl.gpr_waddr  = 4'($urandom_range(15));
		d.ctrl.gpr_wsel   = 3'($urandom_range(7));
		d.ctrl.csr_we     = 1'($urandom_range(1));
		d.ctrl.csr_waddr  = 12'($urandom_range(4095));
		d.ctrl.csr_wsel   = 2'($urandom_range(3));
		d.ctrl.mem_wmask  = 8'($urandom_range(255));
		d.ctrl.mem_rmask  = 3'($urandom_range(7));
		d.ctrl.mem_rw     = 2'($urandom_range(3));
		d.ctrl.is_break   = 1'($urandom_range(1));
		d.ctrl.fence_i    = ($urandom_range(99) < 5);
		d.ctrl.jump       = exe_pkg::JMP_NONE;
		if (!d.ctrl.fence_i && $urandom_range(1) == 1) begin
			d.ctrl.jump = exe_pkg::jump_t'(4'($urandom_range(10, 1)));
		end
		// branches compare rs1 with rs2 through the op the decoder would pick
		case (d.ctrl.jump)
			exe_pkg::JMP_BEQ, exe_pkg::JMP_BNE: d.ctrl.aluop = exe_pkg::ALU_SUB;
			exe_pkg::JMP_BLT, exe_pkg::JMP_BGE: d.ctrl.aluop = exe_pkg::ALU_SLT;
			exe_pkg::JMP_BLTU, exe_pkg::JMP_BGEU: d.ctrl.aluop = exe_pkg::ALU_SLTU;
			default: ;
		endcase
		if (d.ctrl.jump inside {[exe_pkg::JMP_BEQ:exe_pkg::JMP_BGEU]}) begin
			d.ctrl.src_a = 1'b0;
			d.ctrl.src_b = 1'b0;
		end
		return d;
	endfunction

	// handshakes are stable at the falling edge and complete on the next rising one
	always @(negedge clk) begin
		if (rst) begin
			in_taken = 1'b0;
		end else begin
			in_taken = in_valid && in_ready;
			if (in_taken) begin
				exp_q.push_back(model_exe(in_data));
				if (in_data.ctrl.jump != exe_pkg::JMP_NONE) begin
					npc_q.push_back(model_npc(in_data, mtvec, mepc));
				end
			end
			if (icache_flush) begin
				flush_run++;
			end else if (flush_run > 0) begin
				check_flush_len($sformatf("icache_flush run %0d", flush_runs), FLUSH_CYCLES,
					flush_run);
				flush_runs++;
				flush_run = 0;
			end
			if (redirect_valid) begin
				if (npc_q.size() == 0) begin
					err_other++;
					$display("redirect pulse with no jump instruction waiting for one");
				end else begin
					check_redirect($sformatf("redirect_pc %0d", redirects), npc_q.pop_front(),
						redirect_pc);
				end
				redirects++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					err_other++;
					$display("output %0d arrived with nothing expected", received);
				end else begin
					check_result($sformatf("out_data %0d", received), exp_q.pop_front(), out_data);
				end
				if (out_data.ctrl.fence_i) begin
					fence_outs++;
					if (fence_outs > flush_runs) begin
						err_other++;
						$display("fence.i came out before its icache flush had finished");
					end
				end
				received++;
			end
		end
	end

	initial begin
		int sent;
		int total;
		void'($urandom(87077));
		sent      = 0;
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_data   = '0;
		out_ready = 1'b0;
		mtvec     = $urandom() & 32'hffff_fffc;
		mepc      = $urandom() & 32'hffff_fffc;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_flag("out_valid after reset", 1'b0, out_valid);
		check_flag("redirect_valid after reset", 1'b0, redirect_valid);
		check_flag("icache_flush after reset", 1'b0, icache_flush);
		check_flag("in_ready after reset", 1'b1, in_ready);
		while (received < NUM_INSTR) begin
			@(posedge clk);
			#1;
			out_ready = ($urandom_range(3) != 0);
			// a pending instruction holds until it is taken
			if (!in_valid || in_taken) begin
				if (sent < NUM_INSTR && $urandom_range(3) != 0) begin
					in_data  = random_instr();
					in_valid = 1'b1;
					sent++;
				end else begin
					in_valid = 1'b0;
				end
			end
		end
		in_valid  = 1'b0;
		out_ready = 1'b1;
		repeat (10) @(posedge clk);
		if (exp_q.size() != 0 || npc_q.size() != 0) begin
			err_other++;
			$display("%0d results and %0d redirects never came out", exp_q.size(), npc_q.size());
		end
		// one flush run per fence.i, none without one
		if (flush_runs != fence_outs) begin
			err_other++;
			$display("%0d icache flush runs seen for %0d fence.i instructions", flush_runs,
				fence_outs);
		end
		total = err_result + err_redirect + err_flush + err_other;
		$display("errors: result %0d, redirect %0d, flush %0d, other %0d",
			err_result, err_redirect, err_flush, err_other);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// room for every instruction to see a full flush plus pipeline slack
	initial begin
		#(NUM_INSTR * (FLUSH_CYCLES + 8) * CLK_PERIOD);
		$display("watchdog expired with %0d of %0d results received", received, NUM_INSTR);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+dv
logic/exe_pkg.sv
logic/exe_alu.sv
logic/exe_npc.sv
logic/exe_unit.sv
logic/stage_reg.sv
logic/icache_flush_ctrl.sv
logic/exe_top.sv
dv/exe_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the execute stage testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module exe_tb \
	--Mdir obj_dir -o exe_sim

./obj_dir/exe_sim > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
exit 0
